// File: build.f
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_imm_gen.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_core.sv
tb/rv_core_sva.sv
tb/tb_core.sv

// File: run.sh
#!/usr/bin/env bash
# compiles the core with its testbench under verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_core -Mdir obj_dir -o sim_core -f build.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_core
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0

// File: tb/tb_core.sv
`timescale 1ns/1ps

module tb_core;

    localparam int          prog_words   = 256;    // 0x000..0x3fc, last word loops back
    localparam int          mem_words    = 512;    // program plus data at 0x400..0x7fc
    localparam int          fetch_target = 2000;
    localparam int          cycle_limit  = 40000;  // ~4 states per fetch plus ready waits
    localparam int unsigned seed         = 32'h9dc4;

    logic          clk, reset_n, mem_valid, mem_instr, mem_ready;
    rv_pkg::word_t mem_addr, mem_wdata, mem_rdata;
    logic [3:0]    mem_wstrb;

    rv_pkg::word_t mem [mem_words];         // memory seen by the DUT
    rv_pkg::word_t model_mem [mem_words];   // reference copy
    rv_pkg::word_t model_regs [32];
    rv_pkg::word_t model_pc;

    // data transfer the model expects next
    logic          access_pending, access_store;
    rv_pkg::word_t access_addr, access_wdata;

    // captured at the falling edge, applied on the completing edge
    logic          fetch_now, store_now;
    logic [8:0]    store_idx;
    rv_pkg::word_t store_data;

    int fetch_count = 0;
    int cycle_count = 0;

    rv_core #(.reset_pc(32'h0)) u_rv_core (
        .clk       (clk),
        .reset_n   (reset_n),
        .mem_valid (mem_valid),
        .mem_instr (mem_instr),
        .mem_ready (mem_ready),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ----------------------------------------
    // failure reporting
    // ----------------------------------------
    task automatic fail_run(input string what);
        $display("Error: %s", what);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check(input string name, input rv_pkg::word_t expected,
                         input rv_pkg::word_t actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "run stopped at the first error");
        end
    endtask

    // ----------------------------------------
    // instruction encoders
    // ----------------------------------------
    function automatic rv_pkg::word_t r_type(input logic [2:0] f3, input logic [6:0] f7,
                                             input rv_pkg::reg_idx_t rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg};
    endfunction

    function automatic rv_pkg::word_t i_type(input logic [6:0] op, input logic [2:0] f3,
                                             input rv_pkg::reg_idx_t rd, rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    // sw with base x0
    function automatic rv_pkg::word_t s_type(input rv_pkg::reg_idx_t rs2,
                                             input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], rv_pkg::op_store};
    endfunction

    function automatic rv_pkg::word_t b_type(input logic [2:0] f3,
                                             input rv_pkg::reg_idx_t rs1, rs2,
                                             input int offset);
        logic [12:0] o;
        o = offset[12:0];
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], rv_pkg::op_branch};
    endfunction

    function automatic rv_pkg::word_t u_type(input rv_pkg::reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, rv_pkg::op_lui};
    endfunction

    // random program at 0x000..0x3f8, random data above it
    task automatic build_program();
        int               kind, sel, target;
        logic [2:0]       f3, bf3;
        logic [6:0]       f7;
        logic [11:0]      offset;
        rv_pkg::reg_idx_t rd, rs1, rs2;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = $urandom();
        end
        for (int i = 0; i < prog_words - 1; i++) begin
            rd     = 5'($urandom_range(0, 7));   // few registers, many dependencies
            rs1    = 5'($urandom_range(0, 7));
            rs2    = 5'($urandom_range(0, 7));
            kind   = $urandom_range(0, 10);
            sel    = $urandom_range(0, 6);
            offset = 12'(32'h400 + 4 * $urandom_range(0, 255));  // word in the data region
            case (sel)
                1:       f3 = rv_pkg::f3_slt;
                2:       f3 = rv_pkg::f3_sltu;
                3:       f3 = rv_pkg::f3_xor;
                4:       f3 = rv_pkg::f3_or;
                5:       f3 = rv_pkg::f3_and;
                default: f3 = rv_pkg::f3_add;    // 0 add, 6 sub
            endcase
            f7 = (sel == 6) ? rv_pkg::f7_sub : 7'b0;
            case (kind)
                0, 1:    mem[i] = r_type(f3, f7, rd, rs1, rs2);
                2, 3:    mem[i] = i_type(rv_pkg::op_imm, f3, rd, rs1, 12'($urandom()));
                4:       mem[i] = u_type(rd, 20'($urandom()));
                5:       mem[i] = i_type(rv_pkg::op_load, 3'b010, rd, 5'd0, offset);
                6, 7:    mem[i] = s_type(rs2, offset);
                default: begin
                    target = i + $urandom_range(1, 8);     // forward only, never a tight loop
                    if (target > prog_words - 1) begin
                        target = prog_words - 1;
                    end
                    bf3 = 3'($urandom_range(0, 5));
                    if (bf3 >= 3'd2) begin
                        bf3 = bf3 + 3'd2;                  // skip 010 and 011
                    end
                    mem[i] = b_type(bf3, rs1, rs2, (target - i) * 4);
                end
            endcase
        end
        mem[prog_words - 1] = b_type(rv_pkg::f3_beq, 5'd0, 5'd0, -(prog_words - 1) * 4);
        model_mem = mem;
    endtask

    // ----------------------------------------
    // instruction-set model
    // ----------------------------------------
    function automatic rv_pkg::word_t compute_alu(input logic [2:0] f3, input logic sub,
                                                  input rv_pkg::word_t a, b);
        case (f3)
            rv_pkg::f3_add:  return sub ? a - b : a + b;
            rv_pkg::f3_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_pkg::f3_sltu: return (a < b) ? 32'd1 : 32'd0;
            rv_pkg::f3_xor:  return a ^ b;
            rv_pkg::f3_or:   return a | b;
            rv_pkg::f3_and:  return a & b;
            default:         return 32'd0;   // shifts never generated
        endcase
    endfunction

    task automatic execute_model(input rv_pkg::word_t instr);
        rv_pkg::reg_idx_t rd;
        logic [2:0]       f3;
        rv_pkg::word_t    a, b, imm_i, imm_s, imm_b, result, next_pc;
        logic             write_rd, taken;
        rd       = instr[11:7];
        f3       = instr[14:12];
        a        = model_regs[instr[19:15]];
        b        = model_regs[instr[24:20]];
        imm_i    = {{20{instr[31]}}, instr[31:20]};
        imm_s    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b    = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        next_pc  = model_pc + 32'd4;
        write_rd = 1'b0;
        taken    = 1'b0;
        result   = '0;
        case (instr[6:0])
            rv_pkg::op_reg: begin
                write_rd = 1'b1;
                result   = compute_alu(f3, instr[31:25] == rv_pkg::f7_sub, a, b);
            end
            rv_pkg::op_imm: begin
                write_rd = 1'b1;
                result   = compute_alu(f3, 1'b0, a, imm_i);
            end
            rv_pkg::op_lui: begin
                write_rd = 1'b1;
                result   = {instr[31:12], 12'b0};
            end
            rv_pkg::op_load: begin
                write_rd       = 1'b1;
                access_pending = 1'b1;
                access_store   = 1'b0;
                access_addr    = a + imm_i;
                result         = model_mem[access_addr[10:2]];
            end
            rv_pkg::op_store: begin
                access_pending = 1'b1;
                access_store   = 1'b1;
                access_addr    = a + imm_s;
                access_wdata   = b;
                model_mem[access_addr[10:2]] = b;
            end
            rv_pkg::op_branch: begin
                case (f3)
                    rv_pkg::f3_beq:  taken = a == b;
                    rv_pkg::f3_bne:  taken = a != b;
                    rv_pkg::f3_blt:  taken = $signed(a) < $signed(b);
                    rv_pkg::f3_bge:  taken = $signed(a) >= $signed(b);
                    rv_pkg::f3_bltu: taken = a < b;
                    rv_pkg::f3_bgeu: taken = a >= b;
                    default:         taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = model_pc + imm_b;
                end
            end
            default: fail_run("program holds an opcode outside the kept instruction set");
        endcase
        if (write_rd && rd != 5'd0) begin
            model_regs[rd] = result;     // x0 stays zero
        end
        model_pc = next_pc;
    endtask

    // ----------------------------------------
    // memory side, called on falling edges
    // ----------------------------------------
    task automatic drive_bus();
        mem_ready  = mem_valid && ($urandom_range(0, 1) == 1);   // 50% while a request is open
        mem_rdata  = mem[mem_addr[10:2]];
        fetch_now  = mem_ready && mem_instr;
        store_now  = mem_ready && !mem_instr && (mem_wstrb != 4'b0);
        store_idx  = mem_addr[10:2];
        store_data = mem_wdata;
        if (mem_ready && mem_instr) begin
            if (access_pending) begin
                fail_run("fetch started while a load or store was still due");
            end
            check("fetch address", model_pc, mem_addr);
            check("fetch wstrb", 32'h0, {28'h0, mem_wstrb});
            execute_model(mem[model_pc[10:2]]);
        end else if (mem_ready) begin
            if (!access_pending) begin
                fail_run("data transfer without a load or store in flight");
            end
            if (access_store) begin
                check("store address", access_addr, mem_addr);
                check("store data", access_wdata, mem_wdata);
                check("store wstrb", 32'hf, {28'h0, mem_wstrb});
            end else begin
                check("load address", access_addr, mem_addr);
                check("load wstrb", 32'h0, {28'h0, mem_wstrb});
            end
            access_pending = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            fail_run("timeout, the core did not reach the fetch count within the cycle limit");
        end
    end

    initial begin
        void'($urandom(seed));
        reset_n        = 1'b0;
        mem_ready      = 1'b0;
        mem_rdata      = '0;
        access_pending = 1'b0;
        access_store   = 1'b0;
        access_addr    = '0;
        access_wdata   = '0;
        fetch_now      = 1'b0;
        store_now      = 1'b0;
        store_idx      = '0;
        store_data     = '0;
        model_pc       = 32'h0;        // reset_pc
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        build_program();
        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        while (fetch_count < fetch_target) begin
            drive_bus();
            @(posedge clk);
            if (store_now) begin
                mem[store_idx] = store_data;
            end
            if (fetch_now) begin
                fetch_count++;
            end
            @(negedge clk);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: tb/rv_core_sva.sv
`timescale 1ns/1ps

module rv_core_sva (
    input logic          clk,
    input logic          reset_n,
    input logic          mem_valid,
    input logic          mem_instr,
    input logic          mem_ready,
    input rv_pkg::word_t mem_addr,
    input rv_pkg::word_t mem_wdata,
    input logic [3:0]    mem_wstrb
);

    // stalled request keeps every bus output
    a_hold_while_waiting: assert property (@(posedge clk) disable iff (!reset_n)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_instr) && $stable(mem_addr)
                                    && $stable(mem_wdata) && $stable(mem_wstrb))
        else $error("bus outputs changed while a request waited for ready");

    // a fetch never writes
    a_no_write_on_fetch: assert property (@(posedge clk) disable iff (!reset_n)
        mem_wstrb != 4'b0 |-> !mem_instr)
        else $error("write strobes set during an instruction fetch");

    a_fetch_after_reset: assert property (@(posedge clk) !reset_n |=> mem_valid)
        else $error("no fetch request in the first cycle after reset");

endmodule

bind rv_core rv_core_sva u_bus_checks (
    .clk       (clk),
    .reset_n   (reset_n),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb)
);

// File: design/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::word_t reset_pc = '0     // first fetch address
) (
    input  logic          clk,
    input  logic          reset_n,
    // native memory bus
    output logic          mem_valid,
    output logic          mem_instr,
    input  logic          mem_ready,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t mem_wdata,
    output logic [3:0]    mem_wstrb,
    input  rv_pkg::word_t mem_rdata
);

    // ----------------------------------------
    // stage machine state
    // ----------------------------------------
    typedef enum logic [1:0] {
        stage_fetch,
        stage_exec,
        stage_mem,      // lw / sw only
        stage_wb
    } stage_t;

    stage_t        stage_reg, stage_next;
    rv_pkg::word_t pc_reg, pc_next;
    rv_pkg::word_t instr_reg;       // fetched instruction
    rv_pkg::word_t load_reg;        // lw data

    logic in_fetch, in_mem;
    logic fetch_done, mem_done;

    // decoder outputs
    logic            dec_mem_write, dec_mem_read, dec_reg_write;
    logic            dec_in1_from_reg, dec_in2_from_reg, dec_is_branch;
    rv_pkg::alu_op_t dec_alu_op;

    rv_pkg::word_t    imm;
    rv_pkg::reg_idx_t rs1_addr, rs2_addr, rd_addr;
    rv_pkg::word_t    rs1_data, rs2_data, wb_data;
    rv_pkg::word_t    alu_in1, alu_in2, alu_result;
    logic             branch_taken;
    logic             rf_write_en;

    assign in_fetch   = stage_reg == stage_fetch;
    assign in_mem     = stage_reg == stage_mem;
    assign fetch_done = in_fetch && mem_ready;
    assign mem_done   = in_mem && mem_ready;

    // ----------------------------------------
    // bus outputs, purely from stage
    // ----------------------------------------
    assign mem_valid = in_fetch || in_mem;
    assign mem_instr = in_fetch;
    assign mem_addr  = in_fetch ? pc_reg :
                       in_mem   ? alu_result    // rs1 + offset
                                : '0;
    assign mem_wdata = (in_mem && dec_mem_write) ? rs2_data : '0;
    assign mem_wstrb = (in_mem && dec_mem_write) ? 4'b1111 : 4'b0000;   // word stores only

    rv_decoder u_rv_decoder (
        .instr        (instr_reg),
        .mem_write    (dec_mem_write),
        .mem_read     (dec_mem_read),
        .reg_write    (dec_reg_write),
        .in1_from_reg (dec_in1_from_reg),
        .in2_from_reg (dec_in2_from_reg),
        .is_branch    (dec_is_branch),
        .alu_op       (dec_alu_op)
    );

    rv_imm_gen u_rv_imm_gen (
        .instr (instr_reg),
        .imm   (imm)
    );

    // register fields straight from the instruction
    assign rs1_addr = instr_reg[19:15];
    assign rs2_addr = instr_reg[24:20];
    assign rd_addr  = instr_reg[11:7];

    assign rf_write_en = (stage_reg == stage_wb) && dec_reg_write;
    assign wb_data     = dec_mem_read ? load_reg : alu_result;

    rv_regfile u_rv_regfile (
        .clk      (clk),
        .reset_n  (reset_n),
        .write_en (rf_write_en),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .rd_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign alu_in1 = dec_in1_from_reg ? rs1_data : '0;
    assign alu_in2 = dec_in2_from_reg ? rs2_data : imm;

    rv_alu u_rv_alu (
        .in1          (alu_in1),
        .in2          (alu_in2),
        .rs1_val      (rs1_data),
        .rs2_val      (rs2_data),
        .op           (dec_alu_op),
        .funct3       (instr_reg[14:12]),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    // ----------------------------------------
    // next state / next pc
    // ----------------------------------------
    always_comb begin
        stage_next = stage_reg;
        pc_next    = pc_reg;
        case (stage_reg)
            stage_fetch: if (fetch_done) stage_next = stage_exec;   // else wait
            stage_exec: begin
                stage_next = (dec_mem_read || dec_mem_write) ? stage_mem : stage_wb;
            end
            stage_mem: if (mem_done) stage_next = stage_wb;
            stage_wb: begin
                pc_next    = (dec_is_branch && branch_taken) ? pc_reg + imm : pc_reg + 32'd4;
                stage_next = stage_fetch;
            end
            default: stage_next = stage_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            stage_reg <= stage_fetch;
            pc_reg    <= reset_pc;
        end else begin
            stage_reg <= stage_next;
            pc_reg    <= pc_next;
        end
    end

    // data captured only on completing edges
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr_reg <= mem_rdata;
        end
        if (mem_done && dec_mem_read) begin
            load_reg <= mem_rdata;
        end
    end

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             write_en,
    input  rv_pkg::reg_idx_t rs1_addr,
    input  rv_pkg::reg_idx_t rs2_addr,
    input  rv_pkg::reg_idx_t rd_addr,
    input  rv_pkg::word_t    rd_data,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);

    rv_pkg::word_t regs [32];

    // x0 may get written but always reads back zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // single write port
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[rd_addr] <= rd_data;   // visible next cycle
        end
    end

endmodule

// File: design/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::word_t   in1,
    input  rv_pkg::word_t   in2,
    input  rv_pkg::word_t   rs1_val,    // raw register values for the branch compare
    input  rv_pkg::word_t   rs2_val,
    input  rv_pkg::alu_op_t op,
    input  logic [2:0]      funct3,
    output rv_pkg::word_t   result,
    output logic            branch_taken
);

    logic lt_s, lt_u;           // operand compares for slt/sltu
    logic br_eq, br_lt_s, br_lt_u;

    assign lt_s = $signed(in1) < $signed(in2);
    assign lt_u = in1 < in2;

    // ----------------------------------------
    // arithmetic / logic
    // ----------------------------------------
    always_comb begin
        case (op)
            rv_pkg::alu_add:  result = in1 + in2;
            rv_pkg::alu_sub:  result = in1 - in2;
            rv_pkg::alu_and:  result = in1 & in2;
            rv_pkg::alu_or:   result = in1 | in2;
            rv_pkg::alu_xor:  result = in1 ^ in2;
            rv_pkg::alu_slt:  result = {{(rv_pkg::xlen-1){1'b0}}, lt_s};
            rv_pkg::alu_sltu: result = {{(rv_pkg::xlen-1){1'b0}}, lt_u};
            default:          result = '0;
        endcase
    end

    // ----------------------------------------
    // branch condition
    // ----------------------------------------
    assign br_eq   = rs1_val == rs2_val;
    assign br_lt_s = $signed(rs1_val) < $signed(rs2_val);
    assign br_lt_u = rs1_val < rs2_val;

    always_comb begin
        case (funct3)
            rv_pkg::f3_beq:  branch_taken = br_eq;
            rv_pkg::f3_bne:  branch_taken = !br_eq;
            rv_pkg::f3_blt:  branch_taken = br_lt_s;
            rv_pkg::f3_bge:  branch_taken = !br_lt_s;
            rv_pkg::f3_bltu: branch_taken = br_lt_u;
            rv_pkg::f3_bgeu: branch_taken = !br_lt_u;
            default:         branch_taken = 1'b0;   // 010/011 are not branches
        endcase
    end

endmodule

// File: design/rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen (
    input  rv_pkg::word_t instr,
    output rv_pkg::word_t imm
);

    logic [6:0]  opcode;
    logic [11:0] imm_i;     // loads, op_imm
    logic [11:0] imm_s;     // stores
    logic [12:0] imm_b;     // branches, bit 0 always zero
    logic [19:0] imm_u;     // lui

    assign opcode = instr[6:0];

    assign imm_i = instr[31:20];
    assign imm_s = {instr[31:25], instr[11:7]};
    assign imm_b = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = instr[31:12];

    // format picked by opcode, I as fallback
    always_comb begin
        case (opcode)
            rv_pkg::op_store:  imm = {{(rv_pkg::xlen-12){imm_s[11]}}, imm_s};
            rv_pkg::op_branch: imm = {{(rv_pkg::xlen-13){imm_b[12]}}, imm_b};
            rv_pkg::op_lui:    imm = {imm_u, 12'b0};
            default:           imm = {{(rv_pkg::xlen-12){imm_i[11]}}, imm_i};
        endcase
    end

endmodule

// File: design/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  rv_pkg::word_t   instr,
    output logic            mem_write,      // sw
    output logic            mem_read,       // lw
    output logic            reg_write,      // rd gets a result
    output logic            in1_from_reg,   // 0: alu in1 is zero (lui)
    output logic            in2_from_reg,   // 0: alu in2 is the immediate
    output logic            is_branch,
    output rv_pkg::alu_op_t alu_op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // funct3 -> alu op, common to op_reg and op_imm
    function automatic rv_pkg::alu_op_t alu_from_f3(input logic [2:0] f3);
        case (f3)
            rv_pkg::f3_slt:  return rv_pkg::alu_slt;
            rv_pkg::f3_sltu: return rv_pkg::alu_sltu;
            rv_pkg::f3_xor:  return rv_pkg::alu_xor;
            rv_pkg::f3_or:   return rv_pkg::alu_or;
            rv_pkg::f3_and:  return rv_pkg::alu_and;
            default:         return rv_pkg::alu_add;  // add and the dropped shifts
        endcase
    endfunction

    // ----------------------------------------
    // opcode -> control
    // ----------------------------------------
    always_comb begin
        // defaults: no side effects
        mem_write    = 1'b0;
        mem_read     = 1'b0;
        reg_write    = 1'b0;
        in1_from_reg = 1'b1;
        in2_from_reg = 1'b0;
        is_branch    = 1'b0;
        alu_op       = rv_pkg::alu_add;   // address calc for lw/sw, lui passthrough

        case (opcode)
            rv_pkg::op_reg: begin
                reg_write    = 1'b1;
                in2_from_reg = 1'b1;
                // only place funct7 matters
                if (funct3 == rv_pkg::f3_add && funct7 == rv_pkg::f7_sub) begin
                    alu_op = rv_pkg::alu_sub;
                end else begin
                    alu_op = alu_from_f3(funct3);
                end
            end
            rv_pkg::op_imm: begin
                reg_write = 1'b1;
                alu_op    = alu_from_f3(funct3);
            end
            rv_pkg::op_load: begin
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::op_store: begin
                mem_write = 1'b1;
            end
            rv_pkg::op_lui: begin
                reg_write    = 1'b1;
                in1_from_reg = 1'b0;    // 0 + imm
            end
            rv_pkg::op_branch: begin
                is_branch    = 1'b1;
                in2_from_reg = 1'b1;
                alu_op       = rv_pkg::alu_sub;
            end
            default: begin
                // unknown opcode, acts as a nop
            end
        endcase
    end

endmodule

// File: design/rv_pkg.sv
package rv_pkg;

    // ----------------------------------------
    // widths and basic types
    // ----------------------------------------
    localparam int xlen = 32;               // data and address width

    typedef logic [xlen-1:0] word_t;        // one machine word
    typedef logic [4:0]      reg_idx_t;     // x0..x31

    // ----------------------------------------
    // opcodes of the kept instruction classes
    // ----------------------------------------
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,             // lw
        op_imm    = 7'b0010011,             // addi, slti, sltiu, xori, ori, andi
        op_store  = 7'b0100011,             // sw
        op_reg    = 7'b0110011,             // register-register alu ops
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011              // beq .. bgeu
    } opcode_t;

    // alu operations, internal encoding only
    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_and  = 3'd2,
        alu_or   = 3'd3,
        alu_xor  = 3'd4,
        alu_slt  = 3'd5,
        alu_sltu = 3'd6
    } alu_op_t;

    // funct3 of the alu ops, shared by op_reg and op_imm
    localparam logic [2:0] f3_add  = 3'b000;    // add, sub, addi
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct3 of the branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [6:0] f7_sub  = 7'b0100000; // sub vs add in op_reg

endpackage
